// ==== list.f ====
FetchTypes.sv
FetchAddrStage.sv
ICache.sv
ICacheReadStage.sv
FetchController.sv
FetchUnit.sv
FetchChecker.sv
FetchTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module FetchTb -f list.f -o simFetch

status=0
./obj_dir/simFetch > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation reported failures"
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation did not complete"
    exit 1
fi

// ==== FetchTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module FetchTb;
    import FetchTypes::*;

    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 10;
    localparam int INDEX_WIDTH = 4;
    localparam addr_t RESET_PC = 32'h0000_0000;
    localparam addr_t MEM_LIMIT = 32'h0000_1000;
    localparam addr_t REGION_BASE = 32'h0000_0800;                   // lines for hit and invalidate tests.
    localparam int REGION_LINES = 4;
    localparam int TOTAL_FETCHES = 35;                               // sum over all tests.
    localparam int CYCLES_PER_FETCH = 40;
    localparam int MARGIN_CYCLES = 300;
    localparam int WATCHDOG_CYCLES = TOTAL_FETCHES * CYCLES_PER_FETCH + MARGIN_CYCLES;

    logic clk = 1'b0;
    logic rst;
    logic decodeReady;
    logic redirect;
    addr_t redirectPc;
    logic invalidate;
    addr_t wbAdr;
    logic wbCyc;
    logic wbStb;
    word_t wbDatI;
    logic wbAck;
    logic fetchValid;
    logic fetchFault;
    addr_t fetchPc;
    icacheLine_t fetchLine;
    logic invalidateDone;
    int testId;
    logic testEnd;
    logic runEnd;
    int errorTotal;
    logic summaryDone;
    int unsigned seedDiscard;

    always #(CLK_PERIOD / 2) clk = ~clk;

    FetchUnit #(
        .INDEX_WIDTH(INDEX_WIDTH),
        .RESET_PC(RESET_PC),
        .MEM_LIMIT(MEM_LIMIT)
    ) DUT (
        .clk(clk),
        .rst(rst),
        .decodeReady(decodeReady),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .invalidate(invalidate),
        .wbAdr(wbAdr),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbDatI(wbDatI),
        .wbAck(wbAck),
        .fetchValid(fetchValid),
        .fetchFault(fetchFault),
        .fetchPc(fetchPc),
        .fetchLine(fetchLine),
        .invalidateDone(invalidateDone)
    );

    FetchChecker #(
        .RESET_PC(RESET_PC),
        .MEM_LIMIT(MEM_LIMIT),
        .REGION_BASE(REGION_BASE),
        .REGION_LINES(REGION_LINES)
    ) chk (
        .clk(clk),
        .rst(rst),
        .decodeReady(decodeReady),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .pipeStall(DUT.stall),                                       // output register holds while high.
        .fetchValid(fetchValid),
        .fetchFault(fetchFault),
        .fetchPc(fetchPc),
        .fetchLine(fetchLine),
        .invalidateDone(invalidateDone),
        .wbAdr(wbAdr),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbAck(wbAck),
        .testId(testId),
        .testEnd(testEnd),
        .runEnd(runEnd),
        .errorTotal(errorTotal),
        .summaryDone(summaryDone)
    );

    // memory contents seen by the bus slave.
    function automatic word_t memWord(input addr_t wordAddr);
        return (wordAddr * 32'h9E37_79B1) ^ {wordAddr[15:0], wordAddr[31:16]} ^ 32'h5A3C_96E1;
    endfunction

    // wishbone slave, acks each strobe after 0 to 3 idle cycles.
    initial begin
        int waitLeft;
        logic pending;
        wbAck = 1'b0;
        wbDatI = '0;
        waitLeft = 0;
        pending = 1'b0;
        forever begin
            @(negedge clk);
            wbAck = 1'b0;
            if (wbCyc && wbStb) begin
                if (!pending) begin
                    pending = 1'b1;
                    waitLeft = $urandom % 4;
                end
                if (waitLeft == 0) begin
                    wbAck = 1'b1;
                    wbDatI = memWord({2'b00, wbAdr[ADDR_WIDTH-1:2]});
                    pending = 1'b0;
                end else begin
                    waitLeft--;
                end
            end
        end
    end

    // counts accepted fetches, optionally with random ready stretches.
    task automatic waitFetches(input int count, input logic jitter);
        int got;
        int hold;
        got = 0;
        hold = 0;
        while (got < count) begin
            @(posedge clk);
            if (fetchValid && decodeReady && !DUT.stall && !redirect) got++;
            @(negedge clk);
            if (jitter) begin
                if (hold == 0) begin
                    decodeReady = ($urandom % 2) == 0;
                    hold = 1 + $urandom % 4;                         // stretch of 1 to 4 cycles.
                end
                hold--;
            end
        end
        decodeReady = 1'b1;
    endtask

    task automatic redirectTo(input addr_t target);
        redirect = 1'b1;
        redirectPc = target;
        @(negedge clk);
        redirect = 1'b0;
    endtask

    task automatic pulseInvalidate();
        invalidate = 1'b1;
        @(negedge clk);
        invalidate = 1'b0;
    endtask

    task automatic waitInvalidateDone();
        @(posedge clk);
        while (!invalidateDone) @(posedge clk);
        @(negedge clk);
    endtask

    // checker closes the current test at the next edge.
    task automatic finishTest();
        testEnd = 1'b1;
        @(negedge clk);
        testEnd = 1'b0;
        testId = testId + 1;
    endtask

    initial begin
        seedDiscard = $urandom(32'h951dda0b);
        rst = 1'b1;
        decodeReady = 1'b1;
        redirect = 1'b0;
        redirectPc = '0;
        invalidate = 1'b0;
        testId = 0;
        testEnd = 1'b0;
        runEnd = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);                                   // quiet cycles after reset.
        finishTest();
        waitFetches(8, 1'b0);                                        // stream from the reset pc.
        finishTest();
        redirectTo(RESET_PC);
        waitFetches(8, 1'b1);
        finishTest();
        redirectTo(MEM_LIMIT);
        waitFetches(4, 1'b0);
        finishTest();
        redirectTo(32'h0000_002C);                                   // mid-line target.
        waitFetches(3, 1'b0);
        redirectTo(REGION_BASE + 32'h7);                             // fills the region, misses.
        waitFetches(REGION_LINES, 1'b0);
        finishTest();
        redirectTo(REGION_BASE);                                     // all hits now.
        waitFetches(REGION_LINES, 1'b0);
        finishTest();
        pulseInvalidate();
        waitInvalidateDone();
        redirectTo(REGION_BASE);
        waitFetches(REGION_LINES, 1'b0);
        finishTest();
        runEnd = 1'b1;
        wait (summaryDone);
        if (errorTotal == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the fetch stream stopped before all tests were done");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== FetchChecker.sv ====
`timescale 1ns/1ns
`default_nettype none

module FetchChecker #(
    parameter FetchTypes::addr_t RESET_PC = 32'h0000_0000,
    parameter FetchTypes::addr_t MEM_LIMIT = 32'h0000_1000,
    parameter FetchTypes::addr_t REGION_BASE = 32'h0000_0800,
    parameter int REGION_LINES = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic decodeReady,
    input  logic redirect,
    input  FetchTypes::addr_t redirectPc,
    input  logic pipeStall,
    input  logic fetchValid,
    input  logic fetchFault,
    input  FetchTypes::addr_t fetchPc,
    input  FetchTypes::icacheLine_t fetchLine,
    input  logic invalidateDone,
    input  FetchTypes::addr_t wbAdr,
    input  logic wbCyc,
    input  logic wbStb,
    input  logic wbAck,
    input  int testId,
    input  logic testEnd,
    input  logic runEnd,
    output int errorTotal,
    output logic summaryDone
);
    import FetchTypes::*;

    localparam int TEST_REFETCH = 5;
    localparam int TEST_INVAL = 6;

    int testErrors = 0;
    int testFetches = 0;
    int testsRun = 0;
    int failedTests = 0;
    int fetchTotal = 0;
    int regionReads = 0;                                             // acked reads inside the region.
    int doneCount = 0;
    int rstCycles = 0;
    logic wasReset = 1'b0;
    logic holdPrev = 1'b0;                                           // last sample was back-pressured.
    logic heldFault;
    addr_t heldPc;
    icacheLine_t heldLine;
    addr_t expectedPc;

    initial begin
        errorTotal = 0;
        summaryDone = 1'b0;
    end

    function automatic string testName(input int id);
        case (id)
            0: return "reset";
            1: return "sequential";
            2: return "backpressure";
            3: return "fault";
            4: return "redirect";
            5: return "refetch";
            default: return "invalidate";
        endcase
    endfunction

    // memory contents, a mix of every bit of the word address.
    function automatic word_t memWord(input addr_t wordAddr);
        return (wordAddr * 32'h9E37_79B1) ^ {wordAddr[15:0], wordAddr[31:16]} ^ 32'h5A3C_96E1;
    endfunction

    function automatic addr_t lineBase(input addr_t a);
        return {a[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
    endfunction

    // expected line, word 0 in the low bits.
    function automatic icacheLine_t refLine(input addr_t pc);
        icacheLine_t line;
        addr_t wordBase;
        wordBase = {2'b00, pc[ADDR_WIDTH-1:2]};
        for (int w = 0; w < LINE_WORDS; w++)
            line[w*WORD_WIDTH +: WORD_WIDTH] = memWord(wordBase + addr_t'(w));
        return line;
    endfunction

    task automatic reportValue(input string what, input logic [127:0] expected,
                               input logic [127:0] actual);
        $display("ERROR %s: %s expected %0h actual %0h", testName(testId), what, expected, actual);
        testErrors++;
        errorTotal++;
    endtask

    task automatic reportProblem(input string text);
        $display("%s: %s", testName(testId), text);
        testErrors++;
        errorTotal++;
    endtask

    // outputs that must be quiet around reset.
    task automatic checkIdle();
        if (fetchValid !== 1'b0) reportValue("fetchValid", 128'(0), 128'(fetchValid));
        if (wbCyc !== 1'b0) reportValue("wbCyc", 128'(0), 128'(wbCyc));
        if (wbStb !== 1'b0) reportValue("wbStb", 128'(0), 128'(wbStb));
        if (invalidateDone !== 1'b0) reportValue("invalidateDone", 128'(0), 128'(invalidateDone));
    endtask

    task automatic checkFetch();
        logic expFault;
        icacheLine_t expLine;
        expFault = (expectedPc >= MEM_LIMIT);
        expLine = expFault ? '0 : refLine(expectedPc);
        if (fetchPc !== expectedPc) reportValue("pc", 128'(expectedPc), 128'(fetchPc));
        if (fetchFault !== expFault) reportValue("fault", 128'(expFault), 128'(fetchFault));
        if (fetchLine !== expLine) reportValue("line", 128'(expLine), 128'(fetchLine));
        expectedPc = expectedPc + addr_t'(LINE_BYTES);               // next line of the stream.
        testFetches++;
        fetchTotal++;
    endtask

    task automatic closeTest();
        if (testId == TEST_REFETCH)
            if (regionReads != 0) reportValue("region reads", 128'(0), 128'(regionReads));
        if (testId == TEST_INVAL) begin
            if (doneCount != 1) reportValue("done pulses", 128'(1), 128'(doneCount));
            if (regionReads != REGION_LINES * LINE_WORDS)
                reportValue("region reads", 128'(REGION_LINES * LINE_WORDS), 128'(regionReads));
        end
        $display("test %0d %s: %0d fetches checked, %0d errors",
                 testId, testName(testId), testFetches, testErrors);
        testsRun++;
        if (testErrors > 0) failedTests++;
        testErrors = 0;
        testFetches = 0;
        regionReads = 0;
        doneCount = 0;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            rstCycles++;
            if (rstCycles > 1) checkIdle();                          // first edge still sees X.
            expectedPc = lineBase(RESET_PC);
            wasReset = 1'b1;
            holdPrev = 1'b0;
        end else begin
            if (wasReset) checkIdle();                               // first cycle out of reset.
            wasReset = 1'b0;
            if (wbCyc && wbAdr >= MEM_LIMIT)
                reportProblem($sformatf("bus read started for faulting address %0h", wbAdr));
            if (holdPrev && (fetchValid !== 1'b1 || fetchFault !== heldFault ||
                             fetchPc !== heldPc || fetchLine !== heldLine))
                reportProblem($sformatf("fetch outputs changed under back-pressure at pc %0h",
                                        heldPc));
            if (wbCyc && wbStb && wbAck && wbAdr >= REGION_BASE &&
                wbAdr < REGION_BASE + addr_t'(REGION_LINES * LINE_BYTES))
                regionReads++;
            if (invalidateDone) doneCount++;
            if (redirect)
                expectedPc = lineBase(redirectPc);                   // this cycle's fetch is flushed.
            else if (fetchValid && decodeReady && !pipeStall)
                checkFetch();
            holdPrev = !redirect && fetchValid && !decodeReady;
            heldFault = fetchFault;
            heldPc = fetchPc;
            heldLine = fetchLine;
        end
        if (testEnd) closeTest();
        if (runEnd && !summaryDone) begin
            $display("%0d tests run, %0d failed, %0d fetches checked, %0d errors",
                     testsRun, failedTests, fetchTotal, errorTotal);
            summaryDone = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== FetchUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module FetchUnit #(
    parameter int INDEX_WIDTH = 4,
    parameter FetchTypes::addr_t RESET_PC = 32'h0000_0000,
    parameter FetchTypes::addr_t MEM_LIMIT = 32'h0000_1000
) (
    input  logic clk,
    input  logic rst,
    input  logic decodeReady,
    input  logic redirect,
    input  FetchTypes::addr_t redirectPc,
    input  logic invalidate,
    output FetchTypes::addr_t wbAdr,
    output logic wbCyc,
    output logic wbStb,
    input  FetchTypes::word_t wbDatI,
    input  logic wbAck,
    output logic fetchValid,
    output logic fetchFault,
    output FetchTypes::addr_t fetchPc,
    output FetchTypes::icacheLine_t fetchLine,
    output logic invalidateDone
);
    import FetchTypes::*;

    logic stall;
    logic flush;
    logic addrValid;
    logic addrFault;
    addr_t addrPc;
    logic cacheMiss;
    logic invalidateReq;
    logic invalidateAck;

    FetchAddrStage #(
        .RESET_PC(RESET_PC),
        .MEM_LIMIT(MEM_LIMIT)
    ) addrStage (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .addrValid(addrValid),
        .addrFault(addrFault),
        .addrPc(addrPc)
    );

    ICacheReadStage #(
        .INDEX_WIDTH(INDEX_WIDTH)
    ) readStage (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .flush(flush),
        .prevValid(addrValid),
        .prevFault(addrFault),
        .prevPc(addrPc),
        .cacheMiss(cacheMiss),
        .invalidateReq(invalidateReq),
        .invalidateAck(invalidateAck),
        .wbAdr(wbAdr),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbDatI(wbDatI),
        .wbAck(wbAck),
        .outValid(fetchValid),
        .outFault(fetchFault),
        .outPc(fetchPc),
        .outLine(fetchLine)
    );

    FetchController ctrl (
        .clk(clk),
        .rst(rst),
        .cacheMiss(cacheMiss),
        .decodeReady(decodeReady),
        .fetchValid(fetchValid),
        .redirect(redirect),
        .invalidate(invalidate),
        .invalidateAck(invalidateAck),
        .stall(stall),
        .flush(flush),
        .invalidateReq(invalidateReq),
        .invalidateDone(invalidateDone)
    );

endmodule

`default_nettype wire

// ==== FetchController.sv ====
`timescale 1ns/1ns
`default_nettype none

module FetchController (
    input  logic clk,
    input  logic rst,
    input  logic cacheMiss,
    input  logic decodeReady,
    input  logic fetchValid,
    input  logic redirect,
    input  logic invalidate,
    input  logic invalidateAck,
    output logic stall,
    output logic flush,
    output logic invalidateReq,
    output logic invalidateDone
);

    logic invPending;                                                // invalidate seen, not yet acked.

    // hold everything on a miss, on decode back-pressure, or while clearing.
    assign stall = cacheMiss || (fetchValid && !decodeReady) || invPending;
    assign flush = redirect;

    // a running refill finishes first.
    assign invalidateReq = invPending && !cacheMiss;

    always_ff @(posedge clk) begin
        if (rst) begin
            invPending <= 1'b0;
            invalidateDone <= 1'b0;
        end else begin
            invalidateDone <= invalidateAck && invPending;           // one cycle pulse.
            if (invalidate)
                invPending <= 1'b1;                                  // repeated requests merge.
            else if (invalidateAck)
                invPending <= 1'b0;
        end
    end

    // the cache may only finish a walk that was asked for here.
    assert property (@(posedge clk) disable iff (rst)
        invalidateAck |-> invPending)
        else $error("FetchController: invalidate ack without request.");

endmodule

`default_nettype wire

// ==== ICacheReadStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module ICacheReadStage #(
    parameter int INDEX_WIDTH = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  logic flush,
    input  logic prevValid,
    input  logic prevFault,
    input  FetchTypes::addr_t prevPc,
    output logic cacheMiss,
    input  logic invalidateReq,
    output logic invalidateAck,
    output FetchTypes::addr_t wbAdr,
    output logic wbCyc,
    output logic wbStb,
    input  FetchTypes::word_t wbDatI,
    input  logic wbAck,
    output logic outValid,
    output logic outFault,
    output FetchTypes::addr_t outPc,
    output FetchTypes::icacheLine_t outLine
);
    import FetchTypes::*;

    logic lookupEnable;
    logic hitValid;
    icacheLine_t readLine;

    // the old stream must not start a refill in the redirect cycle.
    assign lookupEnable = prevValid && !flush;

    ICache #(
        .INDEX_WIDTH(INDEX_WIDTH)
    ) iCache (
        .clk(clk),
        .rst(rst),
        .fetchEnable(lookupEnable),
        .fetchFault(prevFault),
        .addr(prevPc),
        .hitValid(hitValid),
        .readLine(readLine),
        .cacheMiss(cacheMiss),
        .invalidateReq(invalidateReq),
        .invalidateAck(invalidateAck),
        .wbAdr(wbAdr),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbDatI(wbDatI),
        .wbAck(wbAck)
    );

    // control part of the register toward decode.
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            outValid <= 1'b0;
            outFault <= 1'b0;
        end else if (!stall) begin
            outValid <= hitValid;
            outFault <= prevValid && prevFault;
        end
    end

    // payload part, held under stall.
    always_ff @(posedge clk) begin
        if (!stall) begin
            outPc <= prevPc;
            outLine <= prevFault ? '0 : readLine;                    // fault carries no data.
        end
    end

    // a live lookup that is let through must have hit, or the fetch is lost.
    assert property (@(posedge clk) disable iff (rst)
        (prevValid && !flush && !stall) |-> hitValid)
        else $error("ICacheReadStage: fetch passed without a hit.");

endmodule

`default_nettype wire

// ==== ICache.sv ====
`timescale 1ns/1ns
`default_nettype none

module ICache #(
    parameter int INDEX_WIDTH = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic fetchEnable,
    input  logic fetchFault,
    input  FetchTypes::addr_t addr,
    output logic hitValid,
    output FetchTypes::icacheLine_t readLine,
    output logic cacheMiss,
    input  logic invalidateReq,
    output logic invalidateAck,
    output FetchTypes::addr_t wbAdr,
    output logic wbCyc,
    output logic wbStb,
    input  FetchTypes::word_t wbDatI,
    input  logic wbAck
);
    import FetchTypes::*;

    localparam int LINES = 2 ** INDEX_WIDTH;
    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int WORD_SEL_WIDTH = OFFSET_WIDTH - 2;               // word index in a line.

    localparam logic [2:0] ST_IDLE = 3'd0;                           // lookup only.
    localparam logic [2:0] ST_REQ = 3'd1;                            // bus cycle open.
    localparam logic [2:0] ST_GAP = 3'd2;                            // idle bus between words.
    localparam logic [2:0] ST_INVAL = 3'd3;                          // clearing valid bits.
    localparam logic [2:0] ST_ACK = 3'd4;                            // walk finished.

    logic [LINES-1:0] validBits;
    logic [TAG_WIDTH-1:0] tagArray [LINES];
    icacheLine_t dataArray [LINES];

    logic [INDEX_WIDTH-1:0] lookupIndex;
    logic [TAG_WIDTH-1:0] lookupTag;
    logic lookupHit;
    logic lookupMiss;

    logic [2:0] state;
    logic [WORD_SEL_WIDTH-1:0] wordCnt;
    logic [INDEX_WIDTH-1:0] invCnt;
    addr_t refillBase;
    logic [INDEX_WIDTH-1:0] refillIndex;
    icacheLine_u fillBuf;
    icacheLine_u fillNext;
    logic startRefill;
    logic lastWord;
    logic lineWrite;

    // direct mapped lookup, purely combinational.
    assign lookupIndex = addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign lookupTag = addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign lookupHit = validBits[lookupIndex] && (tagArray[lookupIndex] == lookupTag);
    assign lookupMiss = fetchEnable && !fetchFault && !lookupHit;   // faults never go to memory.

    assign hitValid = fetchEnable && (fetchFault || lookupHit);
    assign readLine = dataArray[lookupIndex];
    assign cacheMiss = (state == ST_REQ) || (state == ST_GAP) ||
                       ((state == ST_IDLE) && lookupMiss);

    // invalidate has priority over a new refill.
    assign startRefill = (state == ST_IDLE) && !invalidateReq && lookupMiss;

    assign refillIndex = refillBase[OFFSET_WIDTH +: INDEX_WIDTH];
    assign lastWord = (wordCnt == WORD_SEL_WIDTH'(LINE_WORDS - 1));
    assign lineWrite = (state == ST_REQ) && wbAck && lastWord;     // last word lands with the line.

    // merge the incoming word into the partly filled line.
    always_comb begin
        fillNext = fillBuf;
        fillNext.words[wordCnt] = wbDatI;
    end

    // wishbone classic read, one word per cycle.
    assign wbCyc = (state == ST_REQ);
    assign wbStb = (state == ST_REQ);
    assign wbAdr = {refillBase[ADDR_WIDTH-1:OFFSET_WIDTH], wordCnt, 2'b00};
    assign invalidateAck = (state == ST_ACK);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            wordCnt <= '0;
            invCnt <= '0;
            validBits <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (invalidateReq) begin
                        state <= ST_INVAL;
                        invCnt <= '0;
                    end else if (startRefill) begin
                        state <= ST_REQ;
                        wordCnt <= '0;                               // ascending from word 0.
                    end
                end
                ST_REQ: begin
                    if (wbAck && lastWord) begin
                        state <= ST_IDLE;
                        validBits[refillIndex] <= 1'b1;
                    end else if (wbAck) begin
                        state <= ST_GAP;
                        wordCnt <= wordCnt + 1'b1;
                    end
                end
                ST_GAP: begin
                    state <= ST_REQ;                                 // cyc was low for a cycle.
                end
                ST_INVAL: begin
                    validBits[invCnt] <= 1'b0;                       // one line per cycle.
                    invCnt <= invCnt + 1'b1;
                    if (&invCnt)
                        state <= ST_ACK;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // arrays and refill buffer.
    always_ff @(posedge clk) begin
        if (startRefill)
            refillBase <= {addr[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
        if ((state == ST_REQ) && wbAck)
            fillBuf <= fillNext;
        if (lineWrite) begin
            dataArray[refillIndex] <= fillNext.raw;
            tagArray[refillIndex] <= refillBase[ADDR_WIDTH-1 -: TAG_WIDTH];
        end
    end

    // the bus goes idle for a cycle after every acked word.
    assert property (@(posedge clk) disable iff (rst) (wbCyc && wbAck) |=> !wbCyc)
        else $error("ICache: cyc stayed high after an ack.");

    // address must not move while the slave is still answering.
    assert property (@(posedge clk) disable iff (rst)
        (wbStb && !wbAck) |=> $stable(wbAdr))
        else $error("ICache: wbAdr changed during a pending strobe.");

endmodule

`default_nettype wire

// ==== FetchAddrStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module FetchAddrStage #(
    parameter FetchTypes::addr_t RESET_PC = 32'h0000_0000,
    parameter FetchTypes::addr_t MEM_LIMIT = 32'h0000_1000
) (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  logic redirect,
    input  FetchTypes::addr_t redirectPc,
    output logic addrValid,
    output logic addrFault,
    output FetchTypes::addr_t addrPc
);
    import FetchTypes::*;

    // drops the byte offset, fetch works on whole lines.
    function automatic addr_t lineBase(input addr_t a);
        return {a[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
    endfunction

    addr_t pcNext;

    assign pcNext = addrPc + addr_t'(LINE_BYTES);                    // next sequential line.

    always_ff @(posedge clk) begin
        if (rst) begin
            addrValid <= 1'b0;                                       // one dead cycle after reset.
            addrPc <= lineBase(RESET_PC);
        end else if (redirect) begin
            // redirect wins over stall.
            addrValid <= 1'b1;
            addrPc <= lineBase(redirectPc);
        end else if (!addrValid) begin
            addrValid <= 1'b1;                                       // reset pc becomes live.
        end else if (!stall) begin
            addrPc <= pcNext;
        end
    end

    // bare mode: physical equals virtual, only the limit check remains.
    assign addrFault = (addrPc >= MEM_LIMIT);

    // the pc never carries an offset, whatever the redirect target was.
    assert property (@(posedge clk) disable iff (rst)
        addrPc[OFFSET_WIDTH-1:0] == '0)
        else $error("FetchAddrStage: pc not line aligned.");

endmodule

`default_nettype wire

// ==== FetchTypes.sv ====
`default_nettype none

package FetchTypes;

    // byte address, used as pc and as physical address.
    localparam int ADDR_WIDTH = 32;
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // one instruction word as carried by the bus.
    localparam int WORD_WIDTH = 32;
    typedef logic [WORD_WIDTH-1:0] word_t;

    // cache line geometry, fixed for the whole front end.
    localparam int LINE_WORDS = 4;                                   // words per line.
    localparam int LINE_BYTES = LINE_WORDS * WORD_WIDTH / 8;         // 16 bytes.
    localparam int OFFSET_WIDTH = $clog2(LINE_BYTES);                // byte offset in a line.

    // the raw line as stored in the data array.
    typedef logic [LINE_WORDS*WORD_WIDTH-1:0] icacheLine_t;

    // same bits, seen either as one vector or as words.
    // word 0 sits in the low bits, it has the lowest address.
    typedef union packed {
        icacheLine_t raw;                                            // array write view.
        logic [LINE_WORDS-1:0][WORD_WIDTH-1:0] words;                // refill view.
    } icacheLine_u;

endpackage

`default_nettype wire
